// ==== hw/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// reorder-buffer tag width
`define TAG_W 4

// load/store queue entries
`define LSQ_DEPTH 8

`endif

// ==== hw/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

	typedef enum logic [6:0] {
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011
	} opcode_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	typedef logic [`TAG_W-1:0] tag_t;

	// addr and data hold the producer tag in their low bits while *_is_tag is set
	typedef struct packed {
		logic        is_store;
		logic [2:0]  funct3;
		tag_t        rd_tag;
		logic [31:0] addr;
		logic        addr_is_tag;
		logic [31:0] imm;
		logic [31:0] data;
		logic        data_is_tag;
	} lsq_entry_t;

endpackage

// ==== hw/ls_decode.sv ====
`timescale 1ns/10ps

module ls_decode (
	input  logic                disp_valid,
	input  logic [31:0]         disp_instr,
	input  lsu_pkg::tag_t       disp_tag,
	input  logic [31:0]         base_value,
	input  logic                base_busy,
	input  logic [31:0]         store_value,
	input  logic                store_busy,
	output logic                enq,
	output lsu_pkg::lsq_entry_t enq_entry
);

	import lsu_pkg::*;

	opcode_t     opcode;
	logic [2:0]  funct3;
	logic        is_load;
	logic        is_store;
	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] imm;

	assign opcode   = opcode_t'(disp_instr[6:0]);
	assign funct3   = disp_instr[14:12];
	assign is_load  = opcode == op_load;
	assign is_store = opcode == op_store;

	// sign-extended offsets, I-type for loads, S-type for stores
	assign i_imm = {{20{disp_instr[31]}}, disp_instr[31:20]};
	assign s_imm = {{20{disp_instr[31]}}, disp_instr[31:25], disp_instr[11:7]};
	assign imm   = is_store ? s_imm : i_imm;

	// anything but a load or store is dropped here
	assign enq = disp_valid && (is_load || is_store);

	always_comb begin
		enq_entry          = '0;
		enq_entry.is_store = is_store;
		enq_entry.funct3   = funct3;
		enq_entry.rd_tag   = disp_tag;
		enq_entry.imm      = imm;

		// busy base keeps the producer tag until the cdb wakes it
		enq_entry.addr_is_tag = base_busy;
		if (base_busy) begin
			enq_entry.addr = base_value;
		end else begin
			enq_entry.addr = base_value + imm;
		end

		// loads carry no store data
		if (is_store) begin
			enq_entry.data        = store_value;
			enq_entry.data_is_tag = store_busy;
		end
	end

endmodule

// ==== hw/ls_queue.sv ====
`timescale 1ns/10ps
`include "lsu_config.svh"

module ls_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                enq,
	input  lsu_pkg::lsq_entry_t enq_entry,
	input  logic                cdb_valid,
	input  lsu_pkg::tag_t       cdb_tag,
	input  logic [31:0]         cdb_data,
	input  logic                commit_valid,
	input  lsu_pkg::tag_t       commit_tag,
	input  logic                issue_ready,
	input  logic                done,
	output logic                disp_ready,
	output logic                issue_valid,
	output lsu_pkg::lsq_entry_t issue_entry
);

	import lsu_pkg::*;

	localparam int PTR_W = $clog2(`LSQ_DEPTH);

	lsq_entry_t       entries [`LSQ_DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W:0]   count;
	logic             issued;

	logic             full;
	logic             do_enq;
	logic             do_deq;
	logic             issue_fire;
	logic [PTR_W-1:0] sel_idx;
	logic             avail;
	logic             operands_ready;
	lsq_entry_t       head_entry;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`LSQ_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// capture a cdb broadcast into any operand waiting on its tag
	function automatic lsq_entry_t wake(
		input lsq_entry_t  e,
		input logic        v,
		input tag_t        t,
		input logic [31:0] d
	);
		lsq_entry_t w;
		w = e;
		if (v && e.addr_is_tag && e.addr[`TAG_W-1:0] == t) begin
			w.addr        = d + e.imm;
			w.addr_is_tag = 1'b0;
		end
		if (v && e.data_is_tag && e.data[`TAG_W-1:0] == t) begin
			w.data        = d;
			w.data_is_tag = 1'b0;
		end
		return w;
	endfunction

	assign full       = count == (PTR_W + 1)'(`LSQ_DEPTH);
	assign disp_ready = ~full;
	assign do_enq     = enq && ~full;
	assign do_deq     = done;

	// on done the head retires this edge, so offer the one behind it
	assign sel_idx    = done ? next_ptr(head) : head;
	assign avail      = done ? (count > (PTR_W + 1)'(1)) : (count != '0);
	assign head_entry = entries[sel_idx];

	always_comb begin
		operands_ready = ~head_entry.addr_is_tag;
		if (head_entry.is_store) begin
			operands_ready = operands_ready && ~head_entry.data_is_tag &&
				commit_valid && (commit_tag == head_entry.rd_tag);
		end
	end

	assign issue_valid = avail && (done || ~issued) && operands_ready;
	assign issue_entry = head_entry;
	assign issue_fire  = issue_valid && issue_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			issued <= 1'b0;
		end else begin
			if (do_enq) begin
				tail <= next_ptr(tail);
			end
			if (do_deq) begin
				head <= next_ptr(head);
			end
			case ({do_enq, do_deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// set for whichever entry is head after this edge
			if (issue_fire) begin
				issued <= 1'b1;
			end else if (do_deq) begin
				issued <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `LSQ_DEPTH; i++) begin
			entries[i] <= wake(entries[i], cdb_valid, cdb_tag, cdb_data);
		end
		// a new entry can be woken in the same cycle it arrives
		if (do_enq) begin
			entries[tail] <= wake(enq_entry, cdb_valid, cdb_tag, cdb_data);
		end
	end

endmodule

// ==== hw/apb_mem_master.sv ====
`timescale 1ns/10ps

module apb_mem_master (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue_valid,
	input  lsu_pkg::lsq_entry_t issue_entry,
	input  logic [31:0]         prdata,
	input  logic                pready,
	output logic                issue_ready,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	output logic [31:0]         paddr,
	output logic [31:0]         pwdata,
	output logic [3:0]          pstrb,
	output logic                done,
	output logic [31:0]         done_rdata,
	output lsu_pkg::lsq_entry_t done_entry
);

	import lsu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t     state;
	lsq_entry_t cur;
	logic [1:0] offset;

	assign issue_ready = state == st_idle;
	assign offset      = cur.addr[1:0];

	// everything below comes from cur, so it holds through the access phase
	assign psel    = state != st_idle;
	assign penable = state == st_access;
	assign pwrite  = cur.is_store;
	assign paddr   = {cur.addr[31:2], 2'b00};
	assign pwdata  = cur.data << {offset, 3'b000};

	always_comb begin
		pstrb = 4'b0000;
		if (cur.is_store) begin
			case (store_funct3_t'(cur.funct3))
				sb:      pstrb = 4'b0001 << offset;
				sh:      pstrb = 4'b0011 << offset;
				sw:      pstrb = 4'b1111;
				default: pstrb = 4'b0000;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (issue_valid) begin
						state <= st_setup;
					end
				end
				st_setup: state <= st_access;
				st_access: begin
					if (pready) begin
						state <= st_idle;
						done  <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid && issue_ready) begin
			cur <= issue_entry;
		end
		if (state == st_access && pready) begin
			done_rdata <= prdata;
			done_entry <= cur;
		end
	end

endmodule

// ==== hw/load_result.sv ====
`timescale 1ns/10ps

module load_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                done,
	input  logic [31:0]         done_rdata,
	input  lsu_pkg::lsq_entry_t done_entry,
	output logic                res_valid,
	output lsu_pkg::tag_t       res_tag,
	output logic [31:0]         res_data
);

	import lsu_pkg::*;

	logic [31:0] shifted;
	logic [31:0] load_value;

	// addressed byte lane down to bit 0
	assign shifted = done_rdata >> {done_entry.addr[1:0], 3'b000};

	always_comb begin
		case (load_funct3_t'(done_entry.funct3))
			lb:      load_value = {{24{shifted[7]}}, shifted[7:0]};
			lh:      load_value = {{16{shifted[15]}}, shifted[15:0]};
			lw:      load_value = shifted;
			lbu:     load_value = {24'd0, shifted[7:0]};
			lhu:     load_value = {16'd0, shifted[15:0]};
			default: load_value = shifted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			res_tag  <= done_entry.rd_tag;
			res_data <= done_entry.is_store ? done_entry.data : load_value;
		end
	end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top (
	input  logic          clk,
	input  logic          rst,
	input  logic          disp_valid,
	input  logic [31:0]   disp_instr,
	input  lsu_pkg::tag_t disp_tag,
	input  logic [31:0]   base_value,
	input  logic          base_busy,
	input  logic [31:0]   store_value,
	input  logic          store_busy,
	output logic          disp_ready,
	input  logic          cdb_valid,
	input  lsu_pkg::tag_t cdb_tag,
	input  logic [31:0]   cdb_data,
	input  logic          commit_valid,
	input  lsu_pkg::tag_t commit_tag,
	output logic          psel,
	output logic          penable,
	output logic          pwrite,
	output logic [31:0]   paddr,
	output logic [31:0]   pwdata,
	output logic [3:0]    pstrb,
	input  logic [31:0]   prdata,
	input  logic          pready,
	output logic          res_valid,
	output lsu_pkg::tag_t res_tag,
	output logic [31:0]   res_data
);

	import lsu_pkg::*;

	logic        enq;
	lsq_entry_t  enq_entry;
	logic        issue_valid;
	logic        issue_ready;
	lsq_entry_t  issue_entry;
	logic        done;
	logic [31:0] done_rdata;
	lsq_entry_t  done_entry;

	ls_decode u_ls_decode (
		.disp_valid  (disp_valid),
		.disp_instr  (disp_instr),
		.disp_tag    (disp_tag),
		.base_value  (base_value),
		.base_busy   (base_busy),
		.store_value (store_value),
		.store_busy  (store_busy),
		.enq         (enq),
		.enq_entry   (enq_entry)
	);

	ls_queue u_ls_queue (
		.clk          (clk),
		.rst          (rst),
		.enq          (enq),
		.enq_entry    (enq_entry),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.commit_valid (commit_valid),
		.commit_tag   (commit_tag),
		.issue_ready  (issue_ready),
		.done         (done),
		.disp_ready   (disp_ready),
		.issue_valid  (issue_valid),
		.issue_entry  (issue_entry)
	);

	apb_mem_master u_apb_mem_master (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_entry (issue_entry),
		.prdata      (prdata),
		.pready      (pready),
		.issue_ready (issue_ready),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pstrb       (pstrb),
		.done        (done),
		.done_rdata  (done_rdata),
		.done_entry  (done_entry)
	);

	load_result u_load_result (
		.clk        (clk),
		.rst        (rst),
		.done       (done),
		.done_rdata (done_rdata),
		.done_entry (done_entry),
		.res_valid  (res_valid),
		.res_tag    (res_tag),
		.res_data   (res_data)
	);

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_tb;

	import lsu_pkg::*;

	localparam int N_OPS = 600;
	localparam int TIMEOUT = 4000;

	logic        clk;
	logic        rst;
	logic        disp_valid;
	logic [31:0] disp_instr;
	tag_t        disp_tag;
	logic [31:0] base_value;
	logic        base_busy;
	logic [31:0] store_value;
	logic        store_busy;
	logic        disp_ready;
	logic        cdb_valid;
	tag_t        cdb_tag;
	logic [31:0] cdb_data;
	logic        commit_valid;
	tag_t        commit_tag;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic [31:0] prdata;
	logic        pready;
	logic        res_valid;
	tag_t        res_tag;
	logic [31:0] res_data;

	logic [31:0] rng;
	logic [31:0] slave_mem [256];
	logic [31:0] model_mem [256];

	// accepted operations in dispatch order
	logic        op_store [N_OPS];
	logic [2:0]  op_f3 [N_OPS];
	tag_t        op_tag [N_OPS];
	logic [31:0] op_addr [N_OPS];
	logic [31:0] op_data [N_OPS];
	int          n_acc;
	int          n_res;
	int          n_apb;
	int          n_ret;
	logic        done_seen;
	logic        saw_full;

	// operation being offered on the dispatch port
	logic        cur_mem;
	logic        cur_store;
	logic [2:0]  cur_f3;
	tag_t        cur_tag;
	logic [31:0] cur_addr;
	logic [31:0] cur_data;
	logic        cur_busy;
	tag_t        next_tag;

	logic        wake_pending;
	logic        wake_armed;
	int          wake_wait;
	tag_t        wake_tag;
	logic [31:0] wake_value;

	logic [31:0] snap_addr;
	logic [31:0] snap_wdata;
	logic [3:0]  snap_strb;
	logic        snap_write;

	lsu_top u_lsu_top (.*);

	assign prdata = slave_mem[paddr[9:2]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s at %0t", msg, $time);
		$display("Finished with errors");
		$fatal(1, "run aborted");
	endtask

	task automatic check_result(input tag_t got_tag, input logic [31:0] got_data,
		input tag_t exp_tag, input logic [31:0] exp_data);
		if (got_tag !== exp_tag || got_data !== exp_data) begin
			$display("error at %0t: result tag %0d data %h, expected tag %0d data %h",
				$time, got_tag, got_data, exp_tag, exp_data);
			$display("Finished with errors");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_apb(input logic [31:0] got_addr, input logic got_write,
		input logic [3:0] got_strb, input logic [31:0] got_wdata,
		input logic [31:0] exp_addr, input logic exp_write,
		input logic [3:0] exp_strb, input logic [31:0] exp_wdata);
		logic [31:0] mask;
		mask = {{8{exp_strb[3]}}, {8{exp_strb[2]}}, {8{exp_strb[1]}}, {8{exp_strb[0]}}};
		if (got_addr !== exp_addr || got_write !== exp_write || got_strb !== exp_strb ||
			(got_wdata & mask) !== (exp_wdata & mask)) begin
			$display("error at %0t: apb addr %h write %b strb %b wdata %h, expected %h %b %b %h",
				$time, got_addr, got_write, got_strb, got_wdata,
				exp_addr, exp_write, exp_strb, exp_wdata);
			$display("Finished with errors");
			$fatal(1, "apb mismatch");
		end
	endtask

	function automatic logic [3:0] strobe_for(input logic [2:0] f3, input logic [1:0] off);
		case (f3[1:0])
			2'd0:    return 4'b0001 << off;
			2'd1:    return 4'b0011 << off;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] load_value(input logic [31:0] word,
		input logic [1:0] off, input logic [2:0] f3);
		logic [31:0] s;
		s = word >> (8 * off);
		case (f3)
			3'b000:  return {{24{s[7]}}, s[7:0]};
			3'b001:  return {{16{s[15]}}, s[15:0]};
			3'b100:  return {24'd0, s[7:0]};
			3'b101:  return {16'd0, s[15:0]};
			default: return s;
		endcase
	endfunction

	task automatic make_op();
		logic [31:0] r;
		logic [31:0] r2;
		logic [11:0] imm;
		logic [31:0] base;
		logic        busy_base;
		logic        busy_data;
		tag_t        ptag;
		r = next_rand();
		r2 = next_rand();
		cur_busy = 1'b0;
		base_busy = 1'b0;
		store_busy = 1'b0;
		cur_mem = r[3:0] != 4'd0;
		if (!cur_mem) begin
			// addi, dropped by decode
			disp_instr = {12'h123, 5'd1, 3'b000, 5'd2, 7'b0010011};
		end else begin
			cur_store = r[4];
			case (r[7:5])
				3'd0: cur_f3 = 3'b000;
				3'd1: cur_f3 = 3'b001;
				3'd2: cur_f3 = 3'b010;
				3'd3: cur_f3 = cur_store ? 3'b000 : 3'b100;
				3'd4: cur_f3 = cur_store ? 3'b001 : 3'b101;
				default: cur_f3 = 3'b010;
			endcase
			cur_addr = {22'd0, r2[27:18]};
			if (cur_f3[1:0] == 2'd1) cur_addr[0] = 1'b0;
			if (cur_f3[1:0] == 2'd2) cur_addr[1:0] = 2'b00;
			imm = r[19:8];
			base = cur_addr - {{20{imm[11]}}, imm};
			cur_data = next_rand();
			cur_tag = next_tag;
			ptag = r2[7:4];
			busy_base = !wake_pending && r2[1:0] == 2'd0 && !(cur_store && r2[2]);
			busy_data = !wake_pending && r2[1:0] == 2'd0 && cur_store && r2[2];
			if (cur_store) begin
				disp_instr = {imm[11:5], 5'd3, 5'd1, cur_f3, imm[4:0], 7'b0100011};
			end else begin
				disp_instr = {imm, 5'd1, cur_f3, 5'd2, 7'b0000011};
			end
			disp_tag = cur_tag;
			base_busy = busy_base;
			base_value = busy_base ? {28'd0, ptag} : base;
			store_busy = busy_data;
			store_value = busy_data ? {28'd0, ptag} : cur_data;
			if (busy_base || busy_data) begin
				cur_busy = 1'b1;
				wake_pending = 1'b1;
				wake_tag = ptag;
				wake_value = busy_base ? base : cur_data;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (disp_ready !== ((n_acc - n_ret) < `LSQ_DEPTH))
				abort_run("disp_ready does not match queue occupancy");
			if (!disp_ready)
				saw_full = 1'b1;
			if (psel && !penable) begin
				snap_addr = paddr;
				snap_wdata = pwdata;
				snap_strb = pstrb;
				snap_write = pwrite;
				if (n_apb >= n_acc)
					abort_run("apb access with no instruction pending");
				if (op_store[n_apb] && commit_tag !== op_tag[n_apb])
					abort_run("store started apb setup before its commit");
			end
			if (psel && penable) begin
				if (paddr !== snap_addr || pwdata !== snap_wdata || pstrb !== snap_strb ||
					pwrite !== snap_write)
					abort_run("apb signals changed during the access phase");
			end
			if (done_seen)
				n_ret++;
			done_seen = 1'b0;
			if (psel && penable && pready) begin
				check_apb(paddr, pwrite, pstrb, pwdata,
					{op_addr[n_apb][31:2], 2'b00}, op_store[n_apb],
					op_store[n_apb] ? strobe_for(op_f3[n_apb], op_addr[n_apb][1:0]) : 4'b0000,
					op_data[n_apb] << (8 * op_addr[n_apb][1:0]));
				if (pwrite) begin
					for (int b = 0; b < 4; b++)
						if (pstrb[b])
							slave_mem[paddr[9:2]][8*b +: 8] <= pwdata[8*b +: 8];
				end
				n_apb++;
				done_seen = 1'b1;
			end
			if (res_valid) begin
				if (n_res >= n_acc)
					abort_run("result with no dispatched instruction");
				if (op_store[n_res]) begin
					check_result(res_tag, res_data, op_tag[n_res], op_data[n_res]);
					for (int b = 0; b < 4; b++)
						if ((strobe_for(op_f3[n_res], op_addr[n_res][1:0]) >> b) & 4'd1)
							model_mem[op_addr[n_res][9:2]][8*b +: 8] =
								8'((op_data[n_res] << (8 * op_addr[n_res][1:0])) >> (8 * b));
				end else begin
					check_result(res_tag, res_data, op_tag[n_res],
						load_value(model_mem[op_addr[n_res][9:2]], op_addr[n_res][1:0],
						op_f3[n_res]));
				end
				n_res++;
			end
			if (disp_valid && disp_ready && cur_mem) begin
				op_store[n_acc] = cur_store;
				op_f3[n_acc] = cur_f3;
				op_tag[n_acc] = cur_tag;
				op_addr[n_acc] = cur_addr;
				op_data[n_acc] = cur_data;
				n_acc++;
			end
		end
	end

	initial begin
		int  stall;
		int  n_gen;
		int  wait_cnt;
		bit  idle;
		bit  heavy;
		rng = 32'hae3a;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_instr = '0;
		disp_tag = '0;
		base_value = '0;
		base_busy = 1'b0;
		store_value = '0;
		store_busy = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit_valid = 1'b0;
		commit_tag = '0;
		pready = 1'b0;
		n_acc = 0;
		n_res = 0;
		n_apb = 0;
		n_ret = 0;
		done_seen = 1'b0;
		saw_full = 1'b0;
		cur_mem = 1'b0;
		next_tag = '0;
		wake_pending = 1'b0;
		wake_armed = 1'b0;
		wake_wait = 0;
		for (int i = 0; i < 256; i++) begin
			slave_mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
			model_mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
		end
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		if (res_valid !== 1'b0 || psel !== 1'b0 || penable !== 1'b0 || disp_ready !== 1'b1)
			abort_run("outputs not in their reset state");
		n_gen = 0;
		stall = 0;
		idle = 1'b1;
		while (n_gen < N_OPS || !idle) begin
			@(posedge clk);
			if (disp_valid && (disp_ready || !cur_mem)) begin
				if (cur_mem)
					next_tag = next_tag + 1'b1;
				if (cur_busy) begin
					wake_armed = 1'b1;
					wake_wait = next_rand() % 8;
				end
				idle = 1'b1;
				stall = 0;
			end else if (disp_valid) begin
				stall++;
				if (stall > TIMEOUT)
					abort_run("dispatch never accepted");
			end
			#1;
			// second half fills the queue with slow pready
			heavy = n_gen > N_OPS / 2;
			pready = heavy ? (next_rand() % 8 == 0) : (next_rand() % 2 != 0);
			commit_valid = next_rand() % 4 != 0;
			commit_tag = n_res < n_acc ? op_tag[n_res] : '0;
			cdb_valid = 1'b0;
			if (wake_armed) begin
				if (wake_wait == 0) begin
					cdb_valid = 1'b1;
					cdb_tag = wake_tag;
					cdb_data = wake_value;
					wake_armed = 1'b0;
					wake_pending = 1'b0;
				end else begin
					wake_wait--;
				end
			end
			if (idle) begin
				disp_valid = 1'b0;
				if (n_gen < N_OPS && n_acc - n_res < 15 && (heavy || next_rand() % 2)) begin
					make_op();
					disp_valid = 1'b1;
					idle = 1'b0;
					n_gen++;
				end
			end
		end
		wait_cnt = 0;
		while (n_res < n_acc || wake_armed) begin
			@(posedge clk);
			#1;
			pready = next_rand() % 2 != 0;
			commit_valid = 1'b1;
			commit_tag = n_res < n_acc ? op_tag[n_res] : '0;
			cdb_valid = 1'b0;
			if (wake_armed) begin
				cdb_valid = 1'b1;
				cdb_tag = wake_tag;
				cdb_data = wake_value;
				wake_armed = 1'b0;
			end
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				abort_run("queue did not drain");
		end
		repeat (20) @(posedge clk);
		if (!saw_full) begin
			abort_run("queue never filled");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/ls_decode.sv
hw/ls_queue.sv
hw/apb_mem_master.sv
hw/load_result.sv
hw/lsu_top.sv
sim/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lsu_tb
BUILD_DIR ?= obj_dir
FILELIST ?= verilog.f
VFLAGS ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
